// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

	localparam int XLEN   = 64;
	localparam int ILEN   = 32;
	localparam int REG_AW = 5;

	// the only system encoding the stage accepts
	localparam logic [ILEN-1:0] ECALL_WORD = 32'h0000_0073;

	// major opcodes in bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_LUI       = 7'b0110111,
		OPC_AUIPC     = 7'b0010111,
		OPC_JAL       = 7'b1101111,
		OPC_JALR      = 7'b1100111,
		OPC_BRANCH    = 7'b1100011,
		OPC_LOAD      = 7'b0000011,
		OPC_STORE     = 7'b0100011,
		OPC_OP_IMM    = 7'b0010011,
		OPC_OP_IMM_32 = 7'b0011011,
		OPC_OP        = 7'b0110011,
		OPC_OP_32     = 7'b0111011,
		OPC_SYSTEM    = 7'b1110011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_MUL,
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU,
		ALU_DIV,
		ALU_DIVU,
		ALU_REM,
		ALU_REMU,
		ALU_BEQ,
		ALU_BNE,
		ALU_BLT,
		ALU_BGE,
		ALU_BLTU,
		ALU_BGEU,
		ALU_JUMP,
		ALU_PASS_IMM
	} alu_op_e;

	typedef enum logic [2:0] {
		FMT_NONE,
		FMT_R,
		FMT_I,
		FMT_SHAMT,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} instr_fmt_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_READ,
		MEM_WRITE
	} mem_access_e;

	// load/store funct3 plus one gives this encoding
	typedef enum logic [2:0] {
		SZ_NONE,
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD,
		SZ_DOUBLE,
		SZ_BYTE_U,
		SZ_HALF_U,
		SZ_WORD_U
	} mem_size_e;

	typedef struct packed {
		logic [ILEN-1:0] instr;
		logic [XLEN-1:0] pc;
	} fetch_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0]   imm;
		alu_op_e           alu_op;
		logic              word_op;
		instr_fmt_e        fmt;
		mem_access_e       mem_access;
		mem_size_e         mem_size;
		logic              reg_write;
		logic              is_branch;
		logic              is_ecall;
		logic              illegal;
	} decoded_instr_t;

endpackage

// File: rtl/pipe_slice.sv
`timescale 1ns/1ns

module pipe_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     i_arst_n,
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);
	logic     valid_q;
	payload_t data_q;

	// take a new item when empty or when the held one leaves this cycle
	assign o_ready = !valid_q || i_ready;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else if (o_ready) begin
			valid_q <= i_valid;
		end
	end

	// payload only moves on an accepted transfer
	always_ff @(posedge clk) begin
		if (i_valid && o_ready) begin
			data_q <= i_data;
		end
	end

	assign o_valid = valid_q;
	assign o_data  = data_q;

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen import rv_decode_pkg::*; (
	input  logic [ILEN-1:0] i_instr,
	input  logic [XLEN-1:0] i_pc,
	input  instr_fmt_e      i_fmt,
	input  logic            i_pc_rel,
	output logic [XLEN-1:0] o_imm
);
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_shamt;

	// sign bit is always instr[31]
	assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{(XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{(XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {{(XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
	assign imm_j = {{(XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// six-bit shift amount for RV64 where word forms keep bit 25 clear
	assign imm_shamt = {{(XLEN-6){1'b0}}, i_instr[25:20]};

	always_comb begin
		case (i_fmt)
			FMT_I: begin
				o_imm = imm_i;
			end
			FMT_SHAMT: begin
				o_imm = imm_shamt;
			end
			FMT_S: begin
				o_imm = imm_s;
			end
			// branch and jal targets are resolved here
			FMT_B: begin
				o_imm = imm_b + i_pc;
			end
			FMT_U: begin
				o_imm = i_pc_rel ? imm_u + i_pc : imm_u;
			end
			FMT_J: begin
				o_imm = imm_j + i_pc;
			end
			default: begin
				o_imm = '0;
			end
		endcase
	end

endmodule

// File: rtl/op_decoder.sv
`timescale 1ns/1ns

module op_decoder import rv_decode_pkg::*; (
	input  logic [ILEN-1:0]   i_instr,
	output instr_fmt_e        o_fmt,
	output logic              o_pc_rel,
	output logic [REG_AW-1:0] o_rd,
	output logic [REG_AW-1:0] o_rs1,
	output logic [REG_AW-1:0] o_rs2,
	output alu_op_e           o_alu_op,
	output logic              o_word_op,
	output logic              o_reg_write,
	output logic              o_is_branch,
	output logic              o_is_ecall,
	output logic              o_illegal,
	output mem_access_e       o_mem_access,
	output mem_size_e         o_mem_size
);
	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	always_comb begin
		o_rd         = i_instr[11:7];
		o_rs1        = i_instr[19:15];
		o_rs2        = i_instr[24:20];
		o_fmt        = FMT_NONE;
		o_pc_rel     = 1'b0;
		o_alu_op     = ALU_NONE;
		o_word_op    = 1'b0;
		o_reg_write  = 1'b0;
		o_is_branch  = 1'b0;
		o_is_ecall   = 1'b0;
		o_illegal    = 1'b0;
		o_mem_access = MEM_NONE;
		o_mem_size   = SZ_NONE;

		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				o_fmt       = FMT_U;
				o_pc_rel    = (opcode == OPC_AUIPC);
				o_alu_op    = ALU_PASS_IMM;
				o_reg_write = 1'b1;
			end
			OPC_JAL: begin
				o_fmt       = FMT_J;
				o_alu_op    = ALU_JUMP;
				o_reg_write = 1'b1;
				o_is_branch = 1'b1;
			end
			// jalr keeps its plain offset since rs1 is added in execute
			OPC_JALR: begin
				o_fmt       = FMT_I;
				o_alu_op    = ALU_JUMP;
				o_reg_write = 1'b1;
				o_is_branch = 1'b1;
				o_illegal   = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				o_fmt       = FMT_B;
				o_is_branch = 1'b1;
				case (funct3)
					3'b000: o_alu_op = ALU_BEQ;
					3'b001: o_alu_op = ALU_BNE;
					3'b100: o_alu_op = ALU_BLT;
					3'b101: o_alu_op = ALU_BGE;
					3'b110: o_alu_op = ALU_BLTU;
					3'b111: o_alu_op = ALU_BGEU;
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				o_fmt        = FMT_I;
				o_alu_op     = ALU_ADD;
				o_reg_write  = 1'b1;
				o_mem_access = MEM_READ;
				o_mem_size   = mem_size_e'(funct3 + 3'd1);
				// no unsigned double
				o_illegal    = (funct3 == 3'b111);
			end
			OPC_STORE: begin
				o_fmt        = FMT_S;
				o_alu_op     = ALU_ADD;
				o_mem_access = MEM_WRITE;
				o_mem_size   = mem_size_e'(funct3 + 3'd1);
				o_illegal    = funct3[2];
			end
			OPC_OP_IMM: begin
				o_fmt       = FMT_I;
				o_reg_write = 1'b1;
				case (funct3)
					3'b000: o_alu_op = ALU_ADD;
					3'b010: o_alu_op = ALU_SLT;
					3'b011: o_alu_op = ALU_SLTU;
					3'b100: o_alu_op = ALU_XOR;
					3'b110: o_alu_op = ALU_OR;
					3'b111: o_alu_op = ALU_AND;
					3'b001: begin
						o_fmt     = FMT_SHAMT;
						o_alu_op  = ALU_SLL;
						o_illegal = (funct7[6:1] != 6'b000000);
					end
					default: begin
						// bit 30 picks arithmetic for srli/srai
						o_fmt     = FMT_SHAMT;
						o_alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
						o_illegal = ({funct7[6], funct7[4:1]} != 5'b00000);
					end
				endcase
			end
			OPC_OP_IMM_32: begin
				o_fmt       = FMT_SHAMT;
				o_word_op   = 1'b1;
				o_reg_write = 1'b1;
				case (funct3)
					3'b000: begin
						o_fmt    = FMT_I;
						o_alu_op = ALU_ADD;
					end
					3'b001: begin
						o_alu_op  = ALU_SLL;
						o_illegal = (funct7 != 7'b0000000);
					end
					3'b101: begin
						o_alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
						o_illegal = ({funct7[6], funct7[4:0]} != 6'b000000);
					end
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_OP: begin
				o_fmt       = FMT_R;
				o_reg_write = 1'b1;
				case (funct7)
					7'b0000000: begin
						case (funct3)
							3'b000: o_alu_op = ALU_ADD;
							3'b001: o_alu_op = ALU_SLL;
							3'b010: o_alu_op = ALU_SLT;
							3'b011: o_alu_op = ALU_SLTU;
							3'b100: o_alu_op = ALU_XOR;
							3'b101: o_alu_op = ALU_SRL;
							3'b110: o_alu_op = ALU_OR;
							default: o_alu_op = ALU_AND;
						endcase
					end
					7'b0100000: begin
						case (funct3)
							3'b000: o_alu_op = ALU_SUB;
							3'b101: o_alu_op = ALU_SRA;
							default: o_illegal = 1'b1;
						endcase
					end
					// M extension
					7'b0000001: begin
						case (funct3)
							3'b000: o_alu_op = ALU_MUL;
							3'b001: o_alu_op = ALU_MULH;
							3'b010: o_alu_op = ALU_MULHSU;
							3'b011: o_alu_op = ALU_MULHU;
							3'b100: o_alu_op = ALU_DIV;
							3'b101: o_alu_op = ALU_DIVU;
							3'b110: o_alu_op = ALU_REM;
							default: o_alu_op = ALU_REMU;
						endcase
					end
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_OP_32: begin
				o_fmt       = FMT_R;
				o_word_op   = 1'b1;
				o_reg_write = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
					{7'b0000000, 3'b001}: o_alu_op = ALU_SLL;
					{7'b0000000, 3'b101}: o_alu_op = ALU_SRL;
					{7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
					{7'b0100000, 3'b101}: o_alu_op = ALU_SRA;
					{7'b0000001, 3'b000}: o_alu_op = ALU_MUL;
					{7'b0000001, 3'b100}: o_alu_op = ALU_DIV;
					{7'b0000001, 3'b101}: o_alu_op = ALU_DIVU;
					{7'b0000001, 3'b110}: o_alu_op = ALU_REM;
					{7'b0000001, 3'b111}: o_alu_op = ALU_REMU;
					default: o_illegal = 1'b1;
				endcase
			end
			// ecall has zero register fields so only the flag is set
			OPC_SYSTEM: begin
				o_is_ecall = (i_instr == ECALL_WORD);
				o_illegal  = (i_instr != ECALL_WORD);
			end
			default: begin
				o_illegal = 1'b1;
			end
		endcase

		// an illegal word carries no side effects downstream
		if (o_illegal) begin
			o_rd         = '0;
			o_rs1        = '0;
			o_rs2        = '0;
			o_fmt        = FMT_NONE;
			o_pc_rel     = 1'b0;
			o_alu_op     = ALU_NONE;
			o_word_op    = 1'b0;
			o_reg_write  = 1'b0;
			o_is_branch  = 1'b0;
			o_mem_access = MEM_NONE;
			o_mem_size   = SZ_NONE;
		end
	end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import rv_decode_pkg::*; (
	input  logic           clk,
	input  logic           i_arst_n,
	input  logic           i_valid,
	output logic           o_ready,
	input  fetch_pkt_t     i_fetch,
	output logic           o_valid,
	input  logic           i_ready,
	output decoded_instr_t o_decoded
);
	fetch_pkt_t        fetch_q;
	logic              fetch_valid;
	logic              dec_ready;
	decoded_instr_t    dec_d;
	instr_fmt_e        fmt;
	logic              pc_rel;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [XLEN-1:0]   imm;
	alu_op_e           alu_op;
	logic              word_op;
	logic              reg_write;
	logic              is_branch;
	logic              is_ecall;
	logic              illegal;
	mem_access_e       mem_access;
	mem_size_e         mem_size;

	pipe_slice #(
		.payload_t(fetch_pkt_t)
	) u_in_slice (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.i_data  (i_fetch),
		.o_valid (fetch_valid),
		.i_ready (dec_ready),
		.o_data  (fetch_q)
	);

	op_decoder u_op_decoder (
		.i_instr     (fetch_q.instr),
		.o_fmt       (fmt),
		.o_pc_rel    (pc_rel),
		.o_rd        (rd),
		.o_rs1       (rs1),
		.o_rs2       (rs2),
		.o_alu_op    (alu_op),
		.o_word_op   (word_op),
		.o_reg_write (reg_write),
		.o_is_branch (is_branch),
		.o_is_ecall  (is_ecall),
		.o_illegal   (illegal),
		.o_mem_access(mem_access),
		.o_mem_size  (mem_size)
	);

	imm_gen u_imm_gen (
		.i_instr (fetch_q.instr),
		.i_pc    (fetch_q.pc),
		.i_fmt   (fmt),
		.i_pc_rel(pc_rel),
		.o_imm   (imm)
	);

	// merge decoder and immediate outputs into one bundle
	always_comb begin
		dec_d.pc         = fetch_q.pc;
		dec_d.rd         = rd;
		dec_d.rs1        = rs1;
		dec_d.rs2        = rs2;
		dec_d.imm        = imm;
		dec_d.alu_op     = alu_op;
		dec_d.word_op    = word_op;
		dec_d.fmt        = fmt;
		dec_d.mem_access = mem_access;
		dec_d.mem_size   = mem_size;
		dec_d.reg_write  = reg_write;
		dec_d.is_branch  = is_branch;
		dec_d.is_ecall   = is_ecall;
		dec_d.illegal    = illegal;
	end

	pipe_slice #(
		.payload_t(decoded_instr_t)
	) u_out_slice (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_valid (fetch_valid),
		.o_ready (dec_ready),
		.i_data  (dec_d),
		.o_valid (o_valid),
		.i_ready (i_ready),
		.o_data  (o_decoded)
	);

endmodule

// File: bench/decode_properties.sv
`timescale 1ns/1ns

module decode_properties import rv_decode_pkg::*; (
	input logic           clk,
	input logic           i_arst_n,
	input logic           i_out_valid,
	input logic           i_out_ready,
	input decoded_instr_t i_decoded
);
	int n_failures = 0;

	// a stalled item stays put until it is taken
	assert property (@(posedge clk) disable iff (!i_arst_n)
		i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_decoded))
	else begin
		$error("decoded output changed while stalled");
		n_failures++;
	end

	assert property (@(posedge clk) !i_arst_n |-> !i_out_valid)
	else begin
		$error("o_valid high during reset");
		n_failures++;
	end

	// illegal words must not write a register or touch memory
	assert property (@(posedge clk) disable iff (!i_arst_n)
		i_out_valid && i_decoded.illegal |->
			!i_decoded.reg_write && i_decoded.mem_access == MEM_NONE)
	else begin
		$error("illegal decode with side effects");
		n_failures++;
	end

endmodule

bind decode_stage decode_properties u_decode_properties (
	.clk        (clk),
	.i_arst_n   (i_arst_n),
	.i_out_valid(o_valid),
	.i_out_ready(i_ready),
	.i_decoded  (o_decoded)
);

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage
	import rv_decode_pkg::*;
();
	localparam int N_ITEMS        = 400;
	localparam int RESET_CYCLES   = 16;
	// about two cycles per item when both sides stall a quarter of the time
	localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * N_ITEMS + 32;
	localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;

	logic           clk;
	logic           i_arst_n;
	logic           i_valid;
	logic           o_ready;
	fetch_pkt_t     i_fetch;
	logic           o_valid;
	logic           i_ready;
	decoded_instr_t o_decoded;

	logic [31:0]    lfsr_state;
	decoded_instr_t exp_q[$];
	int             n_sent;
	int             n_checked;
	int             n_ecall;
	int             n_illegal;
	int             cycles;

	decode_stage DUT (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.o_ready  (o_ready),
		.i_fetch  (i_fetch),
		.o_valid  (o_valid),
		.i_ready  (i_ready),
		.o_decoded(o_decoded)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic compare_values(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	task automatic take_bits(input int count, output logic [63:0] value);
		int k;
		value = '0;
		for (k = 0; k < count; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[62:0], lfsr_state[0]};
		end
	endtask

	// twelve known classes with OP and OP_32 weighted twice plus two unknown opcodes
	function automatic logic [6:0] class_opcode(input logic [3:0] cls);
		case (cls)
			4'd0:  return OPC_LUI;
			4'd1:  return OPC_AUIPC;
			4'd2:  return OPC_JAL;
			4'd3:  return OPC_JALR;
			4'd4:  return OPC_BRANCH;
			4'd5:  return OPC_LOAD;
			4'd6:  return OPC_STORE;
			4'd7:  return OPC_OP_IMM;
			4'd8:  return OPC_OP_IMM_32;
			4'd9:  return OPC_OP;
			4'd10: return OPC_OP;
			4'd11: return OPC_OP_32;
			4'd12: return OPC_OP_32;
			4'd13: return OPC_SYSTEM;
			4'd14: return 7'b0001111;
			default: return 7'b0000000;
		endcase
	endfunction

	task automatic make_fetch(output fetch_pkt_t pkt);
		logic [63:0] r;
		logic [31:0] w;
		logic [1:0]  sel;
		take_bits(32, r);
		w = r[31:0];
		take_bits(4, r);
		w[6:0] = class_opcode(r[3:0]);
		take_bits(2, r);
		sel = r[1:0];
		// steer funct fields toward legal words unless sel is 3
		if (sel != 2'd3) begin
			case (w[6:0])
				OPC_JALR: w[14:12] = 3'b000;
				OPC_OP, OPC_OP_32: begin
					w[31:25] = (sel == 2'd0) ? 7'h00 : (sel == 2'd1) ? 7'h20 : 7'h01;
				end
				OPC_OP_IMM: begin
					if (w[13:12] == 2'b01) begin
						w[31:26] = {1'b0, sel[0] & w[14], 4'b0000};
					end
				end
				OPC_OP_IMM_32: begin
					if (w[13:12] == 2'b01) begin
						w[31:25] = {1'b0, sel[0] & w[14], 5'b00000};
					end
				end
				OPC_SYSTEM: begin
					if (sel[0]) begin
						w = ECALL_WORD;
					end
				end
				default: begin
				end
			endcase
		end
		take_bits(62, r);
		pkt.instr = w;
		pkt.pc    = {r[61:0], 2'b00};
	endtask

	function automatic alu_op_e base_alu(input logic [2:0] f3);
		case (f3)
			3'd0: return ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic alu_op_e mext_alu(input logic [2:0] f3);
		case (f3)
			3'd0: return ALU_MUL;
			3'd1: return ALU_MULH;
			3'd2: return ALU_MULHSU;
			3'd3: return ALU_MULHU;
			3'd4: return ALU_DIV;
			3'd5: return ALU_DIVU;
			3'd6: return ALU_REM;
			default: return ALU_REMU;
		endcase
	endfunction

	// expected decode of one fetch packet from the RV64IM encoding rules
	function automatic decoded_instr_t ref_decode(input fetch_pkt_t pkt);
		decoded_instr_t d;
		logic [31:0]    w;
		logic [2:0]     f3;
		logic [6:0]     f7;
		logic [63:0]    sext_i;
		logic           ok;
		w      = pkt.instr;
		f3     = w[14:12];
		f7     = w[31:25];
		sext_i = {{52{w[31]}}, w[31:20]};
		ok     = 1'b1;
		d      = '0;
		d.rd   = w[11:7];
		d.rs1  = w[19:15];
		d.rs2  = w[24:20];
		case (w[6:0])
			OPC_LUI, OPC_AUIPC: begin
				d.fmt       = FMT_U;
				d.alu_op    = ALU_PASS_IMM;
				d.reg_write = 1'b1;
				d.imm       = {{32{w[31]}}, w[31:12], 12'h000};
				if (w[6:0] == OPC_AUIPC) begin
					d.imm = d.imm + pkt.pc;
				end
			end
			OPC_JAL: begin
				d.fmt       = FMT_J;
				d.alu_op    = ALU_JUMP;
				d.reg_write = 1'b1;
				d.is_branch = 1'b1;
				d.imm       = pkt.pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			OPC_JALR: begin
				d.fmt       = FMT_I;
				d.alu_op    = ALU_JUMP;
				d.reg_write = 1'b1;
				d.is_branch = 1'b1;
				d.imm       = sext_i;
				ok          = (f3 == 3'd0);
			end
			OPC_BRANCH: begin
				d.fmt       = FMT_B;
				d.is_branch = 1'b1;
				d.imm       = pkt.pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				case (f3)
					3'd0: d.alu_op = ALU_BEQ;
					3'd1: d.alu_op = ALU_BNE;
					3'd4: d.alu_op = ALU_BLT;
					3'd5: d.alu_op = ALU_BGE;
					3'd6: d.alu_op = ALU_BLTU;
					3'd7: d.alu_op = ALU_BGEU;
					default: ok = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				d.fmt        = FMT_I;
				d.alu_op     = ALU_ADD;
				d.reg_write  = 1'b1;
				d.mem_access = MEM_READ;
				d.imm        = sext_i;
				case (f3)
					3'd0: d.mem_size = SZ_BYTE;
					3'd1: d.mem_size = SZ_HALF;
					3'd2: d.mem_size = SZ_WORD;
					3'd3: d.mem_size = SZ_DOUBLE;
					3'd4: d.mem_size = SZ_BYTE_U;
					3'd5: d.mem_size = SZ_HALF_U;
					3'd6: d.mem_size = SZ_WORD_U;
					default: ok = 1'b0;
				endcase
			end
			OPC_STORE: begin
				d.fmt        = FMT_S;
				d.alu_op     = ALU_ADD;
				d.mem_access = MEM_WRITE;
				d.imm        = {{52{w[31]}}, w[31:25], w[11:7]};
				case (f3)
					3'd0: d.mem_size = SZ_BYTE;
					3'd1: d.mem_size = SZ_HALF;
					3'd2: d.mem_size = SZ_WORD;
					3'd3: d.mem_size = SZ_DOUBLE;
					default: ok = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				d.reg_write = 1'b1;
				if (f3 == 3'd1 || f3 == 3'd5) begin
					d.fmt    = FMT_SHAMT;
					d.imm    = {58'd0, w[25:20]};
					d.alu_op = (f3 == 3'd1) ? ALU_SLL : (w[30] ? ALU_SRA : ALU_SRL);
					// only bit 30 may be set above the six-bit shamt and only for shifts right
					ok = !w[31] && (w[29:26] == 4'd0) && !(f3 == 3'd1 && w[30]);
				end else begin
					d.fmt    = FMT_I;
					d.imm    = sext_i;
					d.alu_op = base_alu(f3);
				end
			end
			OPC_OP_IMM_32: begin
				d.reg_write = 1'b1;
				d.word_op   = 1'b1;
				if (f3 == 3'd0) begin
					d.fmt    = FMT_I;
					d.imm    = sext_i;
					d.alu_op = ALU_ADD;
				end else if (f3 == 3'd1 || f3 == 3'd5) begin
					d.fmt    = FMT_SHAMT;
					d.imm    = {59'd0, w[24:20]};
					d.alu_op = (f3 == 3'd1) ? ALU_SLL : (w[30] ? ALU_SRA : ALU_SRL);
					ok = !w[31] && (w[29:25] == 5'd0) && !(f3 == 3'd1 && w[30]);
				end else begin
					ok = 1'b0;
				end
			end
			OPC_OP: begin
				d.fmt       = FMT_R;
				d.reg_write = 1'b1;
				if (f7 == 7'h00) begin
					d.alu_op = base_alu(f3);
				end else if (f7 == 7'h01) begin
					d.alu_op = mext_alu(f3);
				end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
					d.alu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
				end else begin
					ok = 1'b0;
				end
			end
			OPC_OP_32: begin
				d.fmt       = FMT_R;
				d.reg_write = 1'b1;
				d.word_op   = 1'b1;
				// word forms drop mulh* and the compare/logic ops
				if (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) begin
					d.alu_op = base_alu(f3);
				end else if (f7 == 7'h01 && (f3 == 3'd0 || f3[2])) begin
					d.alu_op = mext_alu(f3);
				end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
					d.alu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
				end else begin
					ok = 1'b0;
				end
			end
			OPC_SYSTEM: begin
				if (w == ECALL_WORD) begin
					d.is_ecall = 1'b1;
				end else begin
					ok = 1'b0;
				end
			end
			default: begin
				ok = 1'b0;
			end
		endcase
		if (!ok) begin
			d         = '0;
			d.illegal = 1'b1;
		end
		d.pc = pkt.pc;
		return d;
	endfunction

	initial begin
		logic [63:0]    r;
		fetch_pkt_t     pkt;
		decoded_instr_t expected;
		lfsr_state = 32'd87802;
		i_arst_n   = 1'b0;
		i_valid    = 1'b0;
		i_ready    = 1'b0;
		i_fetch    = '0;
		n_sent     = 0;
		n_checked  = 0;
		n_ecall    = 0;
		n_illegal  = 0;
		cycles     = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		i_arst_n <= 1'b1;
		@(posedge clk);
		compare_values("o_valid after reset", 1'b0, o_valid);
		compare_values("o_ready after reset", 1'b1, o_ready);

		while (n_checked < N_ITEMS) begin
			@(posedge clk);
			// values read here are the ones the DUT saw on this edge
			if (i_valid && o_ready) begin
				expected = ref_decode(i_fetch);
				exp_q.push_back(expected);
				n_sent++;
				if (expected.is_ecall) begin
					n_ecall++;
				end
				if (expected.illegal) begin
					n_illegal++;
				end
			end
			if (!i_valid || o_ready) begin
				take_bits(2, r);
				if (n_sent < N_ITEMS && r[1:0] != 2'd0) begin
					make_fetch(pkt);
					i_fetch <= pkt;
					i_valid <= 1'b1;
				end else begin
					i_valid <= 1'b0;
				end
			end
			take_bits(2, r);
			i_ready <= (r[1:0] != 2'd0);
		end

		i_valid <= 1'b0;
		i_ready <= 1'b1;
		repeat (4) @(posedge clk);
		compare_values("o_valid after drain", 1'b0, o_valid);
		compare_values("ecall words seen", 1'b1, n_ecall > 0);
		compare_values("illegal words seen", 1'b1, n_illegal > 0);
		compare_values("assertion failures", 0, DUT.u_decode_properties.n_failures);
		$display("All tests passed");
		$finish;
	end

	// scoreboard pops one expected item per output transfer
	always @(posedge clk) begin
		decoded_instr_t expected;
		if (i_arst_n && o_valid && i_ready) begin
			if (exp_q.size() == 0) begin
				$display("output transfer with no decoded item expected");
				stop_with_failure();
			end else begin
				expected = exp_q.pop_front();
				compare_values($sformatf("item %0d instr at pc %h", n_checked, expected.pc),
					expected, o_decoded);
				n_checked++;
			end
		end
	end

	// a bound assertion that fired ends the run
	always @(posedge clk) begin
		if (DUT.u_decode_properties.n_failures != 0) begin
			$display("a handshake or decode assertion failed");
			stop_with_failure();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d items checked",
				cycles, n_checked, N_ITEMS);
			stop_with_failure();
		end
	end

endmodule

// File: filelist.f
rtl/rv_decode_pkg.sv
rtl/pipe_slice.sv
rtl/imm_gen.sv
rtl/op_decoder.sv
rtl/decode_stage.sv
bench/decode_properties.sv
bench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - rtl/rv_decode_pkg.sv
  - rtl/pipe_slice.sv
  - rtl/imm_gen.sv
  - rtl/op_decoder.sv
  - rtl/decode_stage.sv
  - target: simulation
    files:
      - bench/decode_properties.sv
      - bench/tb_decode_stage.sv
